/* build.f */
design/gf_pkg.sv
design/bch_pkg.sv
design/locator_if.sv
design/bch_ctrl.sv
design/step_counter.sv
design/syndrome_calc.sv
design/key_solver.sv
design/chien_search.sv
design/bch_decoder.sv
dv/tb_clock.sv
dv/bch_decoder_tb.sv

/* dv/bch_decoder_tb.sv */
`timescale 1ns/1ps

module bch_decoder_tb;

	localparam int          DATA_W     = 8;
	localparam int          CHUNKS     = 64 / DATA_W;
	localparam int          NUM_WORDS  = 30;
	localparam int          CLK_PERIOD = 100;
	localparam int          RESET_CYC  = 5;
	localparam int          WATCH_CYC  = NUM_WORDS * (8 + 66 + 200) + RESET_CYC;
	localparam logic [31:0] LFSR_SEED  = 32'h64ee;
	localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
	localparam logic [6:0]  FIELD_POLY = 7'b100_0011;   // x^6 + x + 1

	typedef struct packed {
		logic [5:0] loc;
		logic       last;
		logic [1:0] num_err;
	} beat_t;

	logic              clk;
	logic              i_reset;
	logic              i_valid;
	logic [DATA_W-1:0] i_data;
	logic              o_ready;
	logic              i_out_ready;
	logic              o_out_valid;
	logic              o_out_last;
	logic              o_out_fail;
	logic [5:0]        o_out_loc;
	logic [1:0]        o_out_num_err;

	logic [31:0] lfsr_state;
	logic [12:0] gen_poly;     // m1(x) * m3(x)
	beat_t       exp_q[$];
	beat_t       exp_head;
	logic        exp_any;
	logic        first_seen;
	logic        in_flight;    // eighth chunk taken, status beat not yet
	int          chunk_cnt;
	int          words_done;
	int          errors = 0;
	logic        beat_fire;

	assign beat_fire = o_out_valid && i_out_ready;

	tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.o_clk(clk));

	bch_decoder #(.DATA_W(DATA_W)) uut (
		.clk(clk),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.i_data(i_data),
		.o_ready(o_ready),
		.i_out_ready(i_out_ready),
		.o_out_valid(o_out_valid),
		.o_out_last(o_out_last),
		.o_out_fail(o_out_fail),
		.o_out_loc(o_out_loc),
		.o_out_num_err(o_out_num_err)
	);

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);   // one step per bit
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// m3 is the only monic degree-6 binary polynomial with alpha^3 as a root
	task automatic build_generator();
		logic [5:0] alpha_pow [0:62];
		logic [5:0] acc;
		logic [6:0] m3;
		alpha_pow[0] = 6'd1;
		for (int k = 1; k < 63; k++) begin
			alpha_pow[k] = {alpha_pow[k-1][4:0], 1'b0}
				^ (alpha_pow[k-1][5] ? FIELD_POLY[5:0] : 6'd0);
		end
		m3 = '0;
		for (int f = 0; f < 64; f++) begin
			acc = alpha_pow[18];   // (alpha^3)^6
			for (int k = 0; k < 6; k++) begin
				if (f[k]) begin
					acc = acc ^ alpha_pow[3 * k];
				end
			end
			if (acc == 6'd0) begin
				m3 = {1'b1, 6'(f)};
			end
		end
		gen_poly = '0;
		for (int k = 0; k < 7; k++) begin
			if (FIELD_POLY[k]) begin
				gen_poly = gen_poly ^ (13'(m3) << k);
			end
		end
	endtask

	function automatic logic [62:0] encode(logic [50:0] msg);
		logic [62:0] cw;
		cw = '0;
		for (int i = 0; i < 51; i++) begin
			if (msg[i]) begin
				cw = cw ^ (63'(gen_poly) << i);
			end
		end
		return cw;
	endfunction

	function automatic int pick_pos(int avoid);
		logic [31:0] b;
		b = 32'd63;
		while (b >= 32'd63 || int'(b) == avoid) begin
			b = take_bits(6);
		end
		return int'(b);
	endfunction

	task automatic refresh_head();
		exp_any = (exp_q.size() != 0);
		if (exp_any) begin
			exp_head = exp_q[0];
		end
	endtask

	task automatic push_beat(input int loc, input logic last, input int num);
		exp_q.push_back({6'(loc), last, 2'(num)});
		refresh_head();
	endtask

	task automatic build_word(input int nerr, output logic [63:0] word);
		logic [50:0] msg;
		int          p0;
		int          p1;
		for (int i = 0; i < 51; i++) begin
			msg[i] = 1'(take_bits(1));
		end
		word[62:0] = encode(msg);
		word[63]   = 1'(take_bits(1));   // padding
		p0 = pick_pos(-1);
		p1 = pick_pos(p0);
		if (nerr == 1) begin
			word[p0] = ~word[p0];
			push_beat(p0, 1'b0, 0);
		end else if (nerr == 2) begin
			word[p0] = ~word[p0];
			word[p1] = ~word[p1];
			push_beat(p0 < p1 ? p0 : p1, 1'b0, 0);   // ascending order
			push_beat(p0 < p1 ? p1 : p0, 1'b0, 0);
		end
		push_beat(0, 1'b1, nerr);
	endtask

	always @(posedge clk) begin
		if (i_reset) begin
			first_seen <= 1'b0;
			in_flight  <= 1'b0;
			chunk_cnt  <= 0;
			words_done <= 0;
		end else begin
			if (i_valid && o_ready) begin
				first_seen <= 1'b1;
				if (chunk_cnt == CHUNKS - 1) begin
					chunk_cnt <= 0;
					in_flight <= 1'b1;
				end else begin
					chunk_cnt <= chunk_cnt + 1;
				end
			end
			if (beat_fire && o_out_last) begin
				in_flight  <= 1'b0;
				words_done <= words_done + 1;
			end
		end
	end

	always @(posedge clk) begin
		if (!i_reset && beat_fire && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
			refresh_head();
		end
	end

	// ====================
	// checks
	// ====================
	idle_after_reset: assert property (@(posedge clk) disable iff (i_reset)
		!first_seen |-> o_ready && !o_out_valid)
		else begin
			errors++;
			$display("[FAIL] o_ready/o_out_valid before first chunk: %h/%h, expected 1/0",
				$sampled(o_ready), $sampled(o_out_valid));
		end

	no_extra_beat: assert property (@(posedge clk) disable iff (i_reset)
		beat_fire |-> exp_any)
		else begin
			errors++;
			$display("an output beat arrived when none was expected");
		end

	loc_match: assert property (@(posedge clk) disable iff (i_reset)
		beat_fire && exp_any |-> o_out_loc == exp_head.loc)
		else begin
			errors++;
			$display("[FAIL] o_out_loc got %h expected %h",
				$sampled(o_out_loc), $sampled(exp_head.loc));
		end

	last_match: assert property (@(posedge clk) disable iff (i_reset)
		beat_fire && exp_any |-> o_out_last == exp_head.last)
		else begin
			errors++;
			$display("[FAIL] o_out_last got %h expected %h",
				$sampled(o_out_last), $sampled(exp_head.last));
		end

	num_err_match: assert property (@(posedge clk) disable iff (i_reset)
		beat_fire && exp_any |-> o_out_num_err == exp_head.num_err)
		else begin
			errors++;
			$display("[FAIL] o_out_num_err got %h expected %h",
				$sampled(o_out_num_err), $sampled(exp_head.num_err));
		end

	fail_low: assert property (@(posedge clk) disable iff (i_reset)
		beat_fire |-> !o_out_fail)
		else begin
			errors++;
			$display("[FAIL] o_out_fail got %h expected 0", $sampled(o_out_fail));
		end

	stalled_hold: assert property (@(posedge clk) disable iff (i_reset)
		o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_loc)
			&& $stable(o_out_last) && $stable(o_out_num_err) && $stable(o_out_fail))
		else begin
			errors++;
			$display("a stalled output beat changed or dropped before it was taken");
		end

	busy_not_ready: assert property (@(posedge clk) disable iff (i_reset)
		in_flight |-> !o_ready)
		else begin
			errors++;
			$display("[FAIL] o_ready got %h expected 0 while a word is in flight",
				$sampled(o_ready));
		end

	// ====================
	// stimulus
	// ====================
	initial begin : stimulus
		logic [63:0] word;
		int          w;
		int          c;
		logic        loading;
		i_reset     = 1'b1;
		i_valid     = 1'b0;
		i_data      = '0;
		i_out_ready = 1'b0;
		lfsr_state  = LFSR_SEED;
		word        = '0;
		w           = 0;
		c           = 0;
		loading     = 1'b0;
		refresh_head();
		build_generator();
		repeat (RESET_CYC) @(negedge clk);
		i_reset = 1'b0;
		while (w < NUM_WORDS || loading || exp_q.size() != 0) begin
			if (!loading && w < NUM_WORDS) begin
				build_word(w % 3, word);   // 0, 1, 2 errors in turn
				c       = 0;
				loading = 1'b1;
			end
			i_out_ready = 1'(take_bits(1));
			if (loading) begin
				i_valid = (take_bits(2) != 0);
				i_data  = word[63 - DATA_W * c -: DATA_W];   // msb chunk first
				if (i_valid && o_ready) begin
					c++;
					if (c == CHUNKS) begin
						loading = 1'b0;
						w++;
					end
				end
			end else begin
				i_valid = 1'b0;
			end
			@(negedge clk);
		end
		if (words_done != NUM_WORDS) begin
			errors++;
			$display("saw %0d status beats for %0d words", words_done, NUM_WORDS);
		end
		$display("errors: %0d, words decoded: %0d of %0d", errors, words_done, NUM_WORDS);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCH_CYC * CLK_PERIOD);
		$display("timeout after %0d cycles, the decoder did not finish all words", WATCH_CYC);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;   // 50% duty
	end

endmodule

/* design/bch_decoder.sv */
`timescale 1ns/1ps

module bch_decoder #(
	parameter int DATA_W = 8
) (
	input  logic              clk,
	input  logic              i_reset,

	input  logic              i_valid,
	input  logic [DATA_W-1:0] i_data,
	output logic              o_ready,

	input  logic              i_out_ready,
	output logic              o_out_valid,
	output logic              o_out_last,
	output logic              o_out_fail,
	output logic [5:0]        o_out_loc,
	output logic [1:0]        o_out_num_err
);
	import gf_pkg::*;
	import bch_pkg::*;

	localparam int CHUNKS = WORD_BITS / DATA_W;

	if (WORD_BITS % DATA_W != 0) begin : g_width_check
		$error("bch_decoder: DATA_W must divide the word width");
	end

	logic     count_clear;
	logic     count_en;
	logic     count_last;
	pos_t     count;
	pos_t     limit;
	logic     synd_clear;
	logic     synd_en;
	logic     solve_en;
	logic     search_start;
	logic     search_en;
	logic     report;
	logic     stall;
	logic     report_done;
	gf_elem_t s1;
	gf_elem_t s3;

	locator_if u_locator ();

	// chunk index while loading, bit position otherwise
	assign limit = o_ready ? pos_t'(CHUNKS - 1) : pos_t'(CODE_N - 1);

	// ====================
	// control
	// ====================
	bch_ctrl #(
		.CHUNKS(CHUNKS)
	) u_ctrl (
		.clk(clk),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.o_ready(o_ready),
		.i_count_last(count_last),
		.i_stall(stall),
		.i_report_done(report_done),
		.o_count_clear(count_clear),
		.o_count_en(count_en),
		.o_synd_clear(synd_clear),
		.o_synd_en(synd_en),
		.o_solve_en(solve_en),
		.o_search_start(search_start),
		.o_search_en(search_en),
		.o_report(report)
	);

	step_counter u_counter (
		.clk(clk),
		.i_reset(i_reset),
		.i_clear(count_clear),
		.i_en(count_en),
		.i_limit(limit),
		.o_count(count),
		.o_last(count_last)
	);

	// ====================
	// datapath
	// ====================
	syndrome_calc #(
		.DATA_W(DATA_W)
	) u_syndrome (
		.clk(clk),
		.i_reset(i_reset),
		.i_clear(synd_clear),
		.i_en(synd_en),
		.i_data(i_data),
		.o_s1(s1),
		.o_s3(s3)
	);

	key_solver u_solver (
		.clk(clk),
		.i_reset(i_reset),
		.i_solve_en(solve_en),
		.i_s1(s1),
		.i_s3(s3),
		.loc(u_locator.solver)
	);

	chien_search u_chien (
		.clk(clk),
		.i_reset(i_reset),
		.loc(u_locator.search),
		.i_start(search_start),
		.i_en(search_en),
		.i_report(report),
		.i_pos(count),
		.o_stall(stall),
		.o_report_done(report_done),
		.i_out_ready(i_out_ready),
		.o_out_valid(o_out_valid),
		.o_out_last(o_out_last),
		.o_out_fail(o_out_fail),
		.o_out_loc(o_out_loc),
		.o_out_num_err(o_out_num_err)
	);

endmodule

/* design/chien_search.sv */
`timescale 1ns/1ps

module chien_search (
	input  logic              clk,
	input  logic              i_reset,
	locator_if.search         loc,

	input  logic              i_start,
	input  logic              i_en,
	input  logic              i_report,
	input  bch_pkg::pos_t     i_pos,
	output logic              o_stall,
	output logic              o_report_done,

	input  logic              i_out_ready,
	output logic              o_out_valid,
	output logic              o_out_last,
	output logic              o_out_fail,
	output bch_pkg::pos_t     o_out_loc,
	output bch_pkg::num_err_t o_out_num_err
);
	import gf_pkg::*;
	import bch_pkg::*;

	localparam gf_elem_t STEP1 = gf_pow_const(GF_N - 1);   // alpha^-1
	localparam gf_elem_t STEP2 = gf_pow_const(GF_N - 2);   // alpha^-2

	logic     use_loc;      // first step takes sigma straight from the solver
	gf_elem_t term1_q;
	gf_elem_t term2_q;
	gf_elem_t term1;
	gf_elem_t term2;
	logic     is_root;
	num_err_t root_cnt;
	logic     word_fail;
	logic     load_loc;
	logic     load_status;

	assign term1   = use_loc ? loc.sigma1 : term1_q;
	assign term2   = use_loc ? loc.sigma2 : term2_q;
	assign is_root = ((term1 ^ term2) == gf_elem_t'(1));   // 1 + t1 + t2 == 0

	assign o_stall       = o_out_valid && !i_out_ready;
	assign o_report_done = o_out_valid && o_out_last && i_out_ready;
	assign load_loc      = i_en && is_root;
	assign load_status   = i_report && !o_stall && !(o_out_valid && o_out_last);
	assign word_fail     = loc.fail || (root_cnt != loc.degree);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			use_loc  <= 1'b0;
			root_cnt <= '0;
		end else if (i_start) begin
			use_loc  <= 1'b1;
			root_cnt <= '0;
		end else if (i_en) begin
			use_loc  <= 1'b0;
			if (is_root) begin
				root_cnt <= root_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_en) begin
			term1_q <= gf_mul(term1, STEP1);
			term2_q <= gf_mul(term2, STEP2);
		end
	end

	// ====================
	// output beat
	// ====================
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_out_valid <= 1'b0;
			o_out_last  <= 1'b0;
		end else if (load_loc || load_status) begin
			o_out_valid <= 1'b1;
			o_out_last  <= load_status;
		end else if (i_out_ready) begin
			o_out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load_loc) begin
			o_out_loc     <= i_pos;          // root found one cycle ago
			o_out_fail    <= 1'b0;
			o_out_num_err <= NUM_ERR_NONE;
		end else if (load_status) begin
			o_out_loc     <= STATUS_LOC;
			o_out_fail    <= word_fail;
			o_out_num_err <= word_fail ? NUM_ERR_NONE : loc.degree;
		end
	end

	beat_stable: assert property (@(posedge clk) disable iff (i_reset)
		o_stall |=> o_out_valid && $stable({o_out_loc, o_out_last, o_out_fail, o_out_num_err}));

	// control must freeze the sweep while a beat waits
	no_step_in_stall: assert property (@(posedge clk) disable iff (i_reset)
		i_en |-> !o_stall);

endmodule

/* design/key_solver.sv */
`timescale 1ns/1ps

module key_solver (
	input  logic             clk,
	input  logic             i_reset,
	input  logic             i_solve_en,
	input  gf_pkg::gf_elem_t i_s1,
	input  gf_pkg::gf_elem_t i_s3,
	locator_if.solver        loc
);
	import gf_pkg::*;

	gf_elem_t   s1_sq;
	gf_elem_t   s1_cube;
	gf_elem_t   s3_div;     // S3 / S1
	gf_elem_t   sigma1_d;
	gf_elem_t   sigma2_d;
	logic [1:0] degree_d;
	logic       fail_d;

	assign s1_sq   = gf_mul(i_s1, i_s1);
	assign s1_cube = gf_mul(s1_sq, i_s1);
	assign s3_div  = gf_mul(i_s3, gf_inv(i_s1));

	// Peterson solution for t = 2
	always_comb begin
		sigma1_d = i_s1;
		sigma2_d = '0;
		degree_d = 2'd0;
		fail_d   = 1'b0;
		if (i_s1 == '0 && i_s3 == '0) begin
			degree_d = 2'd0;                  // clean word
		end else if (i_s3 == s1_cube) begin
			degree_d = 2'd1;                  // single error at S1
		end else if (i_s1 != '0) begin
			degree_d = 2'd2;
			sigma2_d = s1_sq ^ s3_div;        // X1 * X2
		end else begin
			fail_d   = 1'b1;                  // more than two errors
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			loc.degree <= 2'd0;
			loc.fail   <= 1'b0;
		end else if (i_solve_en) begin
			loc.degree <= degree_d;
			loc.fail   <= fail_d;
		end
	end

	always_ff @(posedge clk) begin
		if (i_solve_en) begin
			loc.sigma1 <= sigma1_d;
			loc.sigma2 <= sigma2_d;
		end
	end

endmodule

/* design/syndrome_calc.sv */
`timescale 1ns/1ps

module syndrome_calc #(
	parameter int DATA_W = 8
) (
	input  logic              clk,
	input  logic              i_reset,
	input  logic              i_clear,
	input  logic              i_en,
	input  logic [DATA_W-1:0] i_data,
	output gf_pkg::gf_elem_t  o_s1,
	output gf_pkg::gf_elem_t  o_s3
);
	import gf_pkg::*;

	localparam gf_elem_t SHIFT_S1 = gf_pow_const(DATA_W);       // alpha^W
	localparam gf_elem_t SHIFT_S3 = gf_pow_const(3 * DATA_W);   // alpha^3W

	logic              first;    // next chunk holds bit 63
	logic [DATA_W-1:0] chunk;
	gf_elem_t          s1_next;
	gf_elem_t          s3_next;

	// Horner step: earlier chunks sit at higher powers
	always_comb begin
		chunk = i_data;
		if (first) begin
			chunk[DATA_W-1] = 1'b0;   // drop padding bit
		end
		s1_next = gf_mul(o_s1, SHIFT_S1);
		s3_next = gf_mul(o_s3, SHIFT_S3);
		for (int j = 0; j < DATA_W; j++) begin
			if (chunk[j]) begin
				s1_next = s1_next ^ gf_pow_const(j);
				s3_next = s3_next ^ gf_pow_const(3 * j);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset || i_clear) begin
			o_s1  <= '0;
			o_s3  <= '0;
			first <= 1'b1;
		end else if (i_en) begin
			o_s1  <= s1_next;
			o_s3  <= s3_next;
			first <= 1'b0;
		end
	end

endmodule

/* design/step_counter.sv */
`timescale 1ns/1ps

module step_counter (
	input  logic          clk,
	input  logic          i_reset,
	input  logic          i_clear,
	input  logic          i_en,
	input  bch_pkg::pos_t i_limit,
	output bch_pkg::pos_t o_count,
	output logic          o_last
);

	assign o_last = (o_count == i_limit);

	always_ff @(posedge clk) begin
		if (i_reset || i_clear) begin
			o_count <= '0;
		end else if (i_en) begin
			o_count <= o_last ? '0 : o_count + 1'b1;   // wrap at the limit
		end
	end

	// limit is switched by the top level between phases
	count_in_range: assert property (@(posedge clk) disable iff (i_reset)
		o_count <= i_limit);

endmodule

/* design/bch_ctrl.sv */
`timescale 1ns/1ps

module bch_ctrl #(
	parameter int CHUNKS = 8
) (
	input  logic clk,
	input  logic i_reset,

	input  logic i_valid,
	output logic o_ready,

	input  logic i_count_last,
	input  logic i_stall,
	input  logic i_report_done,

	output logic o_count_clear,
	output logic o_count_en,
	output logic o_synd_clear,
	output logic o_synd_en,
	output logic o_solve_en,
	output logic o_search_start,
	output logic o_search_en,
	output logic o_report
);
	import bch_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;
	logic        accept;

	// the chunk index has to fit the shared counter
	if (CHUNKS < 1 || CHUNKS > 2 ** $bits(pos_t)) begin : g_chunks_check
		$error("bch_ctrl: CHUNKS out of range");
	end

	always_comb begin
		state_next = state;
		case (state)
			LOAD: begin
				if (accept && i_count_last) begin
					state_next = SOLVE;      // last chunk of the word
				end
			end
			SOLVE: begin
				state_next = SEARCH;         // single cycle
			end
			SEARCH: begin
				if (i_count_last && !i_stall) begin
					state_next = REPORT;     // position 62 evaluated
				end
			end
			REPORT: begin
				if (i_report_done) begin
					state_next = LOAD;
				end
			end
			default: state_next = LOAD;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= LOAD;
		end else begin
			state <= state_next;
		end
	end

	assign o_ready        = (state == LOAD);
	assign accept         = o_ready && i_valid;
	assign o_synd_en      = accept;
	assign o_solve_en     = (state == SOLVE);
	assign o_search_start = (state == SOLVE);   // arms the term registers
	assign o_search_en    = (state == SEARCH) && !i_stall;
	assign o_report       = (state == REPORT);
	assign o_synd_clear   = o_report && i_report_done;   // entry to LOAD
	assign o_count_clear  = o_solve_en || o_synd_clear;
	assign o_count_en     = accept || o_search_en;

	ready_vs_report: assert property (@(posedge clk) disable iff (i_reset)
		!(o_ready && o_report));

endmodule

/* design/locator_if.sv */
`timescale 1ns/1ps

interface locator_if;
	import gf_pkg::*;

	gf_elem_t   sigma1;   // coefficient of x
	gf_elem_t   sigma2;   // coefficient of x^2
	logic [1:0] degree;   // 0..2
	logic       fail;     // S1 zero, S3 nonzero

	modport solver (
		output sigma1, sigma2, degree, fail
	);

	modport search (
		input sigma1, sigma2, degree, fail
	);

endinterface

/* design/bch_pkg.sv */
package bch_pkg;

	localparam int WORD_BITS = 64;   // received word, bit 63 is padding
	localparam int CODE_N    = 63;
	localparam int T_MAX     = 2;

	typedef logic [$clog2(CODE_N)-1:0]  pos_t;
	typedef logic [$clog2(T_MAX+1)-1:0] num_err_t;

	typedef enum logic [1:0] {
		LOAD,
		SOLVE,
		SEARCH,
		REPORT
	} ctrl_state_t;

	// ====================
	// status beat
	// ====================
	localparam pos_t     STATUS_LOC   = '0;   // loc field of the status beat
	localparam num_err_t NUM_ERR_NONE = '0;   // count reported on failure

endpackage

/* design/gf_pkg.sv */
package gf_pkg;

	localparam int GF_M = 6;
	localparam int GF_N = 2 ** GF_M - 1;                  // multiplicative order
	localparam logic [GF_M:0] GF_POLY = 7'b100_0011;     // x^6 + x + 1

	typedef logic [GF_M-1:0] gf_elem_t;

	// shift-and-add multiply, reducing by GF_POLY after each shift
	function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh  = a;
		for (int i = 0; i < GF_M; i++) begin
			if (b[i]) begin
				acc = acc ^ sh;
			end
			sh = {sh[GF_M-2:0], 1'b0} ^ (sh[GF_M-1] ? GF_POLY[GF_M-1:0] : '0);
		end
		return acc;
	endfunction

	// a^-1 = a^(2^m - 2) = a^2 * a^4 * ... * a^(2^(m-1)); zero maps to zero
	function automatic gf_elem_t gf_inv(gf_elem_t a);
		gf_elem_t sq;
		gf_elem_t r;
		sq = a;
		r  = gf_elem_t'(1);
		for (int i = 1; i < GF_M; i++) begin
			sq = gf_mul(sq, sq);
			r  = gf_mul(r, sq);
		end
		return r;
	endfunction

	function automatic gf_elem_t gf_pow_const(int e);
		gf_elem_t r;
		r = gf_elem_t'(1);
		for (int i = 0; i < e % GF_N; i++) begin
			r = gf_mul(r, gf_elem_t'(2));     // times alpha
		end
		return r;
	endfunction

endpackage
